// File: list.f
fm_pg_pkg.sv
slot_cfg_if.sv
pg_sequencer.sv
pg_cfg_store.sv
pg_phase_gen.sv
pg_delay_ring.sv
fm_pg_top.sv
pg_monitor.sv
tb_fm_pg.sv

// File: tb_fm_pg.sv
/*
 Testbench of the FM phase generator
 Drives configuration writes on falling edges while pg_monitor checks the outputs
*/
`timescale 1ns/1ns

module tb_fm_pg;

	localparam int n             = fm_pg_pkg::num_slots;
	localparam int plain_writes  = n;
	localparam int detune_writes = 32;
	localparam int mul_writes    = 16;
	localparam int kon_writes    = 6;
	localparam int total_writes  = plain_writes + detune_writes + mul_writes + kon_writes;
	// Each write takes up to one frame plus 40 frames of reset and settling
	localparam int timeout_ns    = (total_writes * n + 40 * n) * 10;

	logic                          clk = 1'b0;
	logic                          arst_n;
	logic                          wr_valid;
	logic                          wr_ready;
	logic [fm_pg_pkg::slot_w-1:0]  wr_slot;
	logic [fm_pg_pkg::fnum_w-1:0]  wr_fnum;
	logic [fm_pg_pkg::block_w-1:0] wr_block;
	logic [fm_pg_pkg::mul_w-1:0]   wr_mul;
	logic [fm_pg_pkg::dt_w-1:0]    wr_dt;
	logic                          wr_key_on;
	logic                          phase_valid;
	logic [fm_pg_pkg::slot_w-1:0]  phase_slot;
	logic [fm_pg_pkg::kc_w-1:0]    keycode;
	logic [fm_pg_pkg::phase_w-1:0] phase;

	logic [2:0] test_id;
	int         err_count;
	int         check_count;
	int         wr_count;
	int         tb_errors;
	int         issued;

	// Last settings written per slot for the key-on writes
	logic [10:0] cfg_fnum  [n];
	logic [2:0]  cfg_block [n];
	logic [3:0]  cfg_mul   [n];
	logic [2:0]  cfg_dt    [n];

	// 100 MHz
	always #5 clk = ~clk;

	fm_pg_top fm_pg_top_i (
		.clk(clk), .arst_n(arst_n),
		.wr_valid(wr_valid), .wr_ready(wr_ready), .wr_slot(wr_slot),
		.wr_fnum(wr_fnum), .wr_block(wr_block), .wr_mul(wr_mul), .wr_dt(wr_dt),
		.wr_key_on(wr_key_on),
		.phase_valid(phase_valid), .phase_slot(phase_slot), .keycode(keycode), .phase(phase)
	);

	pg_monitor mon_i (
		.clk(clk), .arst_n(arst_n), .test_id(test_id),
		.wr_valid(wr_valid), .wr_ready(wr_ready), .wr_slot(wr_slot),
		.wr_fnum(wr_fnum), .wr_block(wr_block), .wr_mul(wr_mul), .wr_dt(wr_dt),
		.wr_key_on(wr_key_on),
		.phase_valid(phase_valid), .phase_slot(phase_slot), .keycode(keycode), .phase(phase),
		.err_count(err_count), .check_count(check_count), .wr_count(wr_count)
	);

	// Corners of the keycode rule and the full range
	function automatic logic [10:0] fnum_edge(input int idx);
		case (idx % 8)
			0:       return 11'h000;
			1:       return 11'h001;
			2:       return 11'h37f;
			3:       return 11'h380;
			4:       return 11'h3ff;
			5:       return 11'h400;
			6:       return 11'h480;
			default: return 11'h7ff;
		endcase
	endfunction

	task automatic wait_frames(input int frames);
		repeat (frames * n) @(negedge clk);
	endtask

	// Starts and returns on a falling edge
	task automatic send_write(input int slot, input logic [10:0] fnum, input logic [2:0] block,
		input logic [3:0] mul, input logic [2:0] dt, input logic kon);
		int idle;
		idle = $urandom % 16;
		repeat (idle) @(negedge clk);
		wr_slot   = slot[4:0];
		wr_fnum   = fnum;
		wr_block  = block;
		wr_mul    = mul;
		wr_dt     = dt;
		wr_key_on = kon;
		wr_valid  = 1'b1;
		// Held until the frame boundary window
		while (wr_ready !== 1'b1) @(negedge clk);
		@(negedge clk);
		wr_valid        = 1'b0;
		cfg_fnum[slot]  = fnum;
		cfg_block[slot] = block;
		cfg_mul[slot]   = mul;
		cfg_dt[slot]    = dt;
		issued++;
	endtask

	initial begin : stim
		int          slot;
		int          cnt;
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [3:0]  mul;
		void'($urandom(32'h4b1));
		arst_n    = 1'b0;
		wr_valid  = 1'b0;
		wr_slot   = '0;
		wr_fnum   = '0;
		wr_block  = '0;
		wr_mul    = '0;
		wr_dt     = '0;
		wr_key_on = 1'b0;
		test_id   = 3'd0;
		tb_errors = 0;
		issued    = 0;
		for (int i = 0; i < n; i++) begin
			cfg_fnum[i]  = '0;
			cfg_block[i] = '0;
			cfg_mul[i]   = '0;
			cfg_dt[i]    = '0;
		end

		////////////////////////////////////////
		// Reset and start of the stream
		repeat (16) @(negedge clk);
		if (wr_ready !== 1'b0 || phase_valid !== 1'b0) begin
			tb_errors++;
			$display("Reset: wr_ready or phase_valid not low at the end of reset");
		end
		arst_n = 1'b1;
		cnt    = 0;
		while (phase_valid !== 1'b1 && cnt < 2 * n) begin
			@(negedge clk);
			cnt++;
		end
		// One edge to start plus the pipeline
		if (cnt != fm_pg_pkg::pipe_lat + 1) begin
			tb_errors++;
			$display("FAILED reset phase_valid rise expected %0d actual %0d",
				fm_pg_pkg::pipe_lat + 1, cnt);
		end

		////////////////////////////////////////
		// Plain increments on every slot
		test_id = 3'd1;
		for (int i = 0; i < plain_writes; i++) begin
			send_write(i, fnum_edge(i + i / 8), i % 8, 4'd1, 3'd0, 1'b0);
		end
		wait_frames(4);

		// Detune codes at keycode 0 and 31 and then anywhere
		test_id = 3'd2;
		for (int i = 0; i < detune_writes; i++) begin
			if (i < 8) begin
				fnum  = $urandom % 128;
				block = 3'd0;
			end else if (i < 16) begin
				fnum  = 11'h780 | ($urandom % 128);
				block = 3'd7;
			end else begin
				fnum  = $urandom % 2048;
				block = $urandom % 8;
			end
			mul = (i < 16) ? 4'd1 : $urandom % 16;
			send_write($urandom % n, fnum, block, mul, i % 8, 1'b0);
		end
		wait_frames(3);

		// All multipliers with odd ones on the largest increment
		test_id = 3'd3;
		for (int m = 0; m < mul_writes; m++) begin
			if (m % 2) begin
				fnum  = 11'h7ff;
				block = 3'd7;
			end else begin
				fnum  = $urandom % 2048;
				block = $urandom % 8;
			end
			send_write($urandom % n, fnum, block, m, $urandom % 8, 1'b0);
		end
		wait_frames(3);

		// Key-on with unchanged settings including slot 23
		test_id = 3'd4;
		for (int k = 0; k < kon_writes; k++) begin
			slot = (k * 9 + 5) % n;
			send_write(slot, cfg_fnum[slot], cfg_block[slot], cfg_mul[slot], cfg_dt[slot], 1'b1);
		end
		wait_frames(3);

		test_id = 3'd5;
		wait_frames(2);

		////////////////////////////////////////
		// Closing
		if (wr_count != issued) begin
			tb_errors++;
			$display("FAILED write_count expected %0d actual %0d", issued, wr_count);
		end
		if (check_count == 0) begin
			tb_errors++;
			$display("No output slot was checked");
		end
		$display("Closing: %0d output checks, %0d monitor errors, %0d testbench errors",
			check_count, err_count, tb_errors);
		if (err_count == 0 && tb_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(timeout_ns);
		$display("Timeout: run still going after %0d ns", timeout_ns);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: pg_monitor.sv
/*
 Checker of the FM phase generator that shadows slot settings from the write port
 and compares keycode and phase of every output slot against a reference model
*/
`timescale 1ns/1ns

module pg_monitor (
	input  logic                          clk,
	input  logic                          arst_n,
	// Current test phase for error lines
	input  logic [2:0]                    test_id,
	// Write port
	input  logic                          wr_valid,
	input  logic                          wr_ready,
	input  logic [fm_pg_pkg::slot_w-1:0]  wr_slot,
	input  logic [fm_pg_pkg::fnum_w-1:0]  wr_fnum,
	input  logic [fm_pg_pkg::block_w-1:0] wr_block,
	input  logic [fm_pg_pkg::mul_w-1:0]   wr_mul,
	input  logic [fm_pg_pkg::dt_w-1:0]    wr_dt,
	input  logic                          wr_key_on,
	// Phase stream
	input  logic                          phase_valid,
	input  logic [fm_pg_pkg::slot_w-1:0]  phase_slot,
	input  logic [fm_pg_pkg::kc_w-1:0]    keycode,
	input  logic [fm_pg_pkg::phase_w-1:0] phase,
	// Totals for the closing line
	output int                            err_count,
	output int                            check_count,
	output int                            wr_count
);

	localparam int n = fm_pg_pkg::num_slots;
	// Output slot on the stream while slot 23 is being read
	localparam int window_slot = n - 1 - fm_pg_pkg::pipe_lat;

	// Settings as the output stream sees them
	logic [fm_pg_pkg::fnum_w-1:0]  sh_fnum  [n];
	logic [fm_pg_pkg::block_w-1:0] sh_block [n];
	logic [fm_pg_pkg::mul_w-1:0]   sh_mul   [n];
	logic [fm_pg_pkg::dt_w-1:0]    sh_dt    [n];
	logic                          sh_kon   [n];
	logic [fm_pg_pkg::acc_w-1:0]   sh_acc   [n];

	// Accepted writes as {key_on, fnum, block, mul, dt}
	logic [4:0]  pend_slot [$];
	logic [21:0] pend_cfg  [$];

	logic running;
	int   exp_slot;

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd0:    return "reset";
			3'd1:    return "plain_inc";
			3'd2:    return "detune";
			3'd3:    return "multiplier";
			3'd4:    return "key_on";
			default: return "drain";
		endcase
	endfunction

	////////////////////////////////////////
	// Reference model
	function automatic logic [4:0] ref_keycode(input logic [10:0] fnum, input logic [2:0] block);
		logic low;
		// Rounds the note towards the upper half of the octave
		if (fnum[10]) begin
			low = |fnum[9:7];
		end else begin
			low = &fnum[9:7];
		end
		return {block, fnum[10], low};
	endfunction

	// Fractional powers of two as 16 times 2^(i/8)
	function automatic int frac_pow2(input int idx);
		case (idx)
			0:       return 16;
			1:       return 17;
			2:       return 19;
			3:       return 20;
			4:       return 22;
			5:       return 24;
			6:       return 26;
			default: return 29;
		endcase
	endfunction

	function automatic logic [16:0] ref_phinc(input logic [10:0] fnum, input logic [2:0] block,
		input logic [3:0] mul, input logic [2:0] dt);
		int base;
		int kf;
		int raw;
		int cap;
		int off;
		int inc;
		base = (int'(fnum) << block) >> 1;
		kf   = int'(ref_keycode(fnum, block));
		case (dt[1:0])
			2'd1:    kf = kf - 4;
			2'd2:    kf = kf + 4;
			2'd3:    kf = kf + 8;
			default: kf = kf;
		endcase
		// Octave 4 takes the table value as is
		if (kf < 0) begin
			raw = 0;
		end else if (kf / 8 <= 4) begin
			raw = frac_pow2(kf % 8) >> (4 - kf / 8);
		end else begin
			raw = frac_pow2(kf % 8) << (kf / 8 - 4);
		end
		case (dt[1:0])
			2'd2:    cap = 16;
			2'd3:    cap = 22;
			default: cap = 8;
		endcase
		off = (raw > cap) ? cap : raw;
		if (dt[1:0] == 2'd0) begin
			inc = base;
		end else if (dt[2]) begin
			inc = base - off;
		end else begin
			inc = base + off;
		end
		inc = inc & 32'h1ffff;
		// Multiplier 0 stands for one half
		if (mul == 4'd0) begin
			inc = inc >> 1;
		end else begin
			inc = (inc * int'(mul)) & 32'h1ffff;
		end
		return inc[16:0];
	endfunction

	// New settings land at the frame start
	task automatic apply_pending();
		logic [21:0] c;
		int s;
		while (pend_slot.size() > 0) begin
			s = pend_slot.pop_front();
			c = pend_cfg.pop_front();
			sh_kon[s]   = sh_kon[s] | c[21];
			sh_fnum[s]  = c[20:10];
			sh_block[s] = c[9:7];
			sh_mul[s]   = c[6:3];
			sh_dt[s]    = c[2:0];
		end
	endtask

	initial begin
		err_count   = 0;
		check_count = 0;
		wr_count    = 0;
		running     = 1'b0;
		exp_slot    = 0;
		for (int i = 0; i < n; i++) begin
			sh_fnum[i]  = '0;
			sh_block[i] = '0;
			sh_mul[i]   = '0;
			sh_dt[i]    = '0;
			sh_kon[i]   = 1'b0;
			sh_acc[i]   = '0;
		end
	end

	////////////////////////////////////////
	// Reset values, sampled mid-cycle
	always @(negedge clk) begin
		if (!arst_n && (wr_ready !== 1'b0 || phase_valid !== 1'b0)) begin
			err_count++;
			$display("Reset: wr_ready or phase_valid is high while arst_n is low");
		end
	end

	////////////////////////////////////////
	// Comparison on the rising edge
	always @(posedge clk) begin : check_proc
		logic [fm_pg_pkg::kc_w-1:0]    exp_kc;
		logic [fm_pg_pkg::phase_w-1:0] exp_ph;
		logic                          exp_rdy;
		int                            s;
		if (!arst_n) begin
			running  = 1'b0;
			exp_slot = 0;
		end else begin
			// Window open exactly while slot 23 is read
			exp_rdy = (exp_slot == window_slot);
			if (wr_ready !== exp_rdy) begin
				err_count++;
				$display("FAILED %s wr_ready expected %0b actual %0b",
					test_name(test_id), exp_rdy, wr_ready);
			end
			if (phase_valid === 1'b1) begin
				check_count++;
				running  = 1'b1;
				s        = exp_slot;
				exp_slot = (s + 1) % n;
				if (phase_slot !== s[4:0]) begin
					err_count++;
					$display("FAILED %s phase_slot expected %0d actual %0d",
						test_name(test_id), s, phase_slot);
				end
				if (s == 0) begin
					apply_pending();
				end
				exp_kc = ref_keycode(sh_fnum[s], sh_block[s]);
				// Key-on restarts from zero for this one output
				if (sh_kon[s]) begin
					sh_acc[s] = '0;
					sh_kon[s] = 1'b0;
				end else begin
					sh_acc[s] = sh_acc[s] + ref_phinc(sh_fnum[s], sh_block[s],
						sh_mul[s], sh_dt[s]);
				end
				exp_ph = sh_acc[s][19:10];
				if (keycode !== exp_kc) begin
					err_count++;
					$display("FAILED %s keycode slot %0d expected %0h actual %0h",
						test_name(test_id), s, exp_kc, keycode);
				end
				if (phase !== exp_ph) begin
					err_count++;
					$display("FAILED %s phase slot %0d expected %0h actual %0h",
						test_name(test_id), s, exp_ph, phase);
				end
			end else if (running) begin
				err_count++;
				$display("Output stream stopped, phase_valid low where slot %0d was due", exp_slot);
			end
			// Handshake fires on this edge
			if (wr_valid === 1'b1 && wr_ready === 1'b1) begin
				pend_slot.push_back(wr_slot);
				pend_cfg.push_back({wr_key_on, wr_fnum, wr_block, wr_mul, wr_dt});
				wr_count++;
			end
		end
	end

endmodule

// File: fm_pg_top.sv
/*
 FM phase generator top with host write port and phase stream
 One operator slot per clock, 24 slots per frame
*/
`timescale 1ns/1ns

module fm_pg_top (
	input  logic                          clk,
	input  logic                          arst_n,
	// Host configuration write
	input  logic                          wr_valid,
	output logic                          wr_ready,
	input  logic [fm_pg_pkg::slot_w-1:0]  wr_slot,
	input  logic [fm_pg_pkg::fnum_w-1:0]  wr_fnum,
	input  logic [fm_pg_pkg::block_w-1:0] wr_block,
	input  logic [fm_pg_pkg::mul_w-1:0]   wr_mul,
	input  logic [fm_pg_pkg::dt_w-1:0]    wr_dt,
	input  logic                          wr_key_on,
	// Phase stream
	output logic                          phase_valid,
	output logic [fm_pg_pkg::slot_w-1:0]  phase_slot,
	output logic [fm_pg_pkg::kc_w-1:0]    keycode,
	output logic [fm_pg_pkg::phase_w-1:0] phase
);

	// Sequencer read side
	logic [fm_pg_pkg::slot_w-1:0] rd_slot;
	logic                         rd_valid;

	// Handshake fires and write fields packed
	wire wr_en = wr_valid && wr_ready;
	wire fm_pg_pkg::slot_cfg_t wr_cfg = '{fnum: wr_fnum, block: wr_block, mul: wr_mul, dt: wr_dt};

	// Phase feedback and output tag
	logic [fm_pg_pkg::acc_w-1:0] acc_next, fb_acc;
	fm_pg_pkg::slot_tag_t        tag_next, tag_q;

	slot_cfg_if cfg_if ();

	pg_sequencer seq_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.rd_slot  (rd_slot),
		.rd_valid (rd_valid),
		.wr_ready (wr_ready)
	);

	pg_cfg_store store_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_slot   (rd_slot),
		.rd_valid  (rd_valid),
		.wr_en     (wr_en),
		.wr_slot   (wr_slot),
		.wr_cfg    (wr_cfg),
		.wr_key_on (wr_key_on),
		.cfg       (cfg_if.store)
	);

	pg_phase_gen gen_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.cfg         (cfg_if.gen),
		.fb_acc      (fb_acc),
		.tag_in      (tag_q),
		.acc_next    (acc_next),
		.tag_out     (tag_next),
		.keycode     (keycode),
		.phase       (phase),
		.phase_valid (phase_valid),
		.phase_slot  (phase_slot)
	);

	// Accumulator returns one frame later for the same slot
	pg_delay_ring #(
		.payload_t (logic [fm_pg_pkg::acc_w-1:0]),
		.depth     (fm_pg_pkg::ring_len)
	) phase_ring_i (
		.clk    (clk),
		.arst_n (arst_n),
		.din    (acc_next),
		.dout   (fb_acc)
	);

	// Tag lines up with the registered phase
	pg_delay_ring #(
		.payload_t (fm_pg_pkg::slot_tag_t),
		.depth     (1)
	) tag_ring_i (
		.clk    (clk),
		.arst_n (arst_n),
		.din    (tag_next),
		.dout   (tag_q)
	);

endmodule

// File: pg_delay_ring.sv
/*
 Resettable shift line of a chosen payload type
 Serves as the one-frame phase feedback and as the output tag delay
*/
`timescale 1ns/1ns

module pg_delay_ring #(
	parameter type payload_t = logic,
	parameter int  depth     = 1
) (
	input  logic     clk,
	input  logic     arst_n,
	input  payload_t din,
	output payload_t dout
);

	// Stage 0 is the newest entry
	payload_t line_q [depth];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			line_q <= '{default: '0};
		end else begin
			line_q[0] <= din;
			// Move every entry one stage on
			for (int i = 1; i < depth; i++) begin
				line_q[i] <= line_q[i-1];
			end
		end
	end

	// Oldest entry, depth cycles after entry
	assign dout = line_q[depth-1];

endmodule

// File: pg_phase_gen.sv
/*
 Phase increment pipeline and accumulator of the FM phase generator
 Settings enter from slot_cfg_if and the new accumulator leaves for the feedback ring
*/
`timescale 1ns/1ns

module pg_phase_gen (
	input  logic                          clk,
	input  logic                          arst_n,
	slot_cfg_if.gen                       cfg,
	// Same slot's accumulator, one frame old
	input  logic [fm_pg_pkg::acc_w-1:0]   fb_acc,
	// Tag back from the alignment ring
	input  fm_pg_pkg::slot_tag_t          tag_in,
	output logic [fm_pg_pkg::acc_w-1:0]   acc_next,
	output fm_pg_pkg::slot_tag_t          tag_out,
	output logic [fm_pg_pkg::kc_w-1:0]    keycode,
	output logic [fm_pg_pkg::phase_w-1:0] phase,
	output logic                          phase_valid,
	output logic [fm_pg_pkg::slot_w-1:0]  phase_slot
);

	// Sideband stage registers
	fm_pg_pkg::slot_tag_t         tag_s [1:5];
	logic [1:5]                   kon_s;
	logic [fm_pg_pkg::dt_w-1:0]   dt_s  [1:3];
	logic [fm_pg_pkg::mul_w-1:0]  mul_s [1:4];

	// Datapath
	logic [fm_pg_pkg::phinc_w:0]   blk_shift;
	logic [fm_pg_pkg::kc_w-1:0]    kc_s0;
	logic [fm_pg_pkg::phinc_w-1:0] phinc_s1, phinc_s2, phinc_s3, phinc_s4, phinc_s5;
	logic [5:0]                    dt_kf_s2;
	logic [4:0]                    pow2, dt_cap, dt_off_s3;
	logic [5:0]                    dt_raw;
	logic [fm_pg_pkg::phinc_w+fm_pg_pkg::mul_w-1:0] mul_prod;

	// Slot tag, key-on and late-used fields ride beside the data
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tag_s <= '{default: '0};
			kon_s <= '0;
			dt_s  <= '{default: '0};
			mul_s <= '{default: '0};
		end else begin
			tag_s[1] <= '{valid: cfg.rd_valid, slot: cfg.rd_slot, keycode: kc_s0};
			kon_s[1] <= cfg.key_on;
			dt_s[1]  <= cfg.cfg.dt;
			mul_s[1] <= cfg.cfg.mul;
			for (int i = 2; i <= 5; i++) begin
				tag_s[i] <= tag_s[i-1];
				kon_s[i] <= kon_s[i-1];
			end
			for (int i = 2; i <= 3; i++) begin
				dt_s[i] <= dt_s[i-1];
			end
			for (int i = 2; i <= 4; i++) begin
				mul_s[i] <= mul_s[i-1];
			end
		end
	end

	////////////////////////////////////////
	// Stage 1 block shift and keycode
	// Octave shift, halved so block 1 passes fnum unchanged
	assign blk_shift = {7'd0, cfg.cfg.fnum} << cfg.cfg.block;
	// Fifth bit rounds fnum bits 9..7 towards the upper note
	assign kc_s0 = {cfg.cfg.block, cfg.cfg.fnum[10],
		cfg.cfg.fnum[10] ? (|cfg.cfg.fnum[9:7]) : (&cfg.cfg.fnum[9:7])};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phinc_s1 <= '0;
		end else begin
			phinc_s1 <= blk_shift[fm_pg_pkg::phinc_w:1];
		end
	end

	////////////////////////////////////////
	// Stage 2 detuned keycode
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dt_kf_s2 <= '0;
			phinc_s2 <= '0;
		end else begin
			case (dt_s[1][1:0])
				2'd1:    dt_kf_s2 <= {1'b0, tag_s[1].keycode} - 6'd4;
				2'd2:    dt_kf_s2 <= {1'b0, tag_s[1].keycode} + 6'd4;
				2'd3:    dt_kf_s2 <= {1'b0, tag_s[1].keycode} + 6'd8;
				default: dt_kf_s2 <= {1'b0, tag_s[1].keycode};
			endcase
			phinc_s2 <= phinc_s1;
		end
	end

	////////////////////////////////////////
	// Stage 3 detune offset
	assign pow2   = fm_pg_pkg::dt_pow2[dt_kf_s2[2:0]];
	assign dt_cap = fm_pg_pkg::dt_limit[dt_s[2][1:0]];

	// Octave of the detuned keycode scales the offset
	always_comb begin
		case (dt_kf_s2[5:3])
			3'd0:    dt_raw = {5'd0, pow2[4]};
			3'd1:    dt_raw = {4'd0, pow2[4:3]};
			3'd2:    dt_raw = {3'd0, pow2[4:2]};
			3'd3:    dt_raw = {2'd0, pow2[4:1]};
			3'd4:    dt_raw = {1'd0, pow2};
			3'd5:    dt_raw = {pow2, 1'b0};
			// Also catches a wrapped negative keycode
			default: dt_raw = 6'd0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dt_off_s3 <= '0;
			phinc_s3  <= '0;
		end else begin
			dt_off_s3 <= (dt_raw > {1'b0, dt_cap}) ? dt_cap : dt_raw[4:0];
			phinc_s3  <= phinc_s2;
		end
	end

	////////////////////////////////////////
	// Stage 4 apply detune, then stage 5 multiply
	assign mul_prod = phinc_s4 * mul_s[4];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phinc_s4 <= '0;
			phinc_s5 <= '0;
		end else begin
			if (dt_s[3][1:0] == 2'd0) begin
				phinc_s4 <= phinc_s3;
			end else if (!dt_s[3][2]) begin
				phinc_s4 <= phinc_s3 + dt_off_s3;
			end else begin
				phinc_s4 <= phinc_s3 - dt_off_s3;
			end
			// Multiplier 0 means one half
			if (mul_s[4] == '0) begin
				phinc_s5 <= {1'b0, phinc_s4[fm_pg_pkg::phinc_w-1:1]};
			end else begin
				phinc_s5 <= mul_prod[fm_pg_pkg::phinc_w-1:0];
			end
		end
	end

	////////////////////////////////////////
	// Stage 6 accumulate
	// Key-on restarts the slot from zero
	assign acc_next = kon_s[5] ? '0 : fb_acc + {3'd0, phinc_s5};
	assign tag_out  = tag_s[5];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase <= '0;
		end else begin
			phase <= acc_next[fm_pg_pkg::acc_w-1 -: fm_pg_pkg::phase_w];
		end
	end

	// Tag comes back aligned with the phase register
	assign phase_valid = tag_in.valid;
	assign phase_slot  = tag_in.slot;
	assign keycode     = tag_in.keycode;

endmodule

// File: pg_cfg_store.sv
/*
 Per-slot configuration array with one-shot key-on flags
 Written by the host handshake and read once per cycle onto slot_cfg_if
*/
`timescale 1ns/1ns

module pg_cfg_store (
	input  logic                         clk,
	input  logic                         arst_n,
	// Sequencer read side
	input  logic [fm_pg_pkg::slot_w-1:0] rd_slot,
	input  logic                         rd_valid,
	// Host write side
	input  logic                         wr_en,
	input  logic [fm_pg_pkg::slot_w-1:0] wr_slot,
	input  fm_pg_pkg::slot_cfg_t         wr_cfg,
	input  logic                         wr_key_on,
	// Registered read data
	slot_cfg_if.store                    cfg
);

	// Slot settings
	fm_pg_pkg::slot_cfg_t cfg_mem [fm_pg_pkg::num_slots];

	// Key-on waiting for its slot's next read
	logic [fm_pg_pkg::num_slots-1:0] kon_pend;

	////////////////////////////////////////
	// Settings array
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg_mem <= '{default: '0};
		end else if (wr_en) begin
			cfg_mem[wr_slot] <= wr_cfg;
		end
	end

	////////////////////////////////////////
	// Key-on flags
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			kon_pend <= '0;
		end else begin
			// Consumed by the read
			if (rd_valid) begin
				kon_pend[rd_slot] <= 1'b0;
			end
			// New request wins over a read of the same slot
			if (wr_en && wr_key_on) begin
				kon_pend[wr_slot] <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Read port
	// Old contents on a same-cycle write
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg.cfg      <= '0;
			cfg.key_on   <= 1'b0;
			cfg.rd_valid <= 1'b0;
			cfg.rd_slot  <= '0;
		end else begin
			cfg.cfg      <= cfg_mem[rd_slot];
			cfg.key_on   <= rd_valid && kon_pend[rd_slot];
			cfg.rd_valid <= rd_valid;
			cfg.rd_slot  <= rd_slot;
		end
	end

endmodule

// File: pg_sequencer.sv
/*
 Slot sequencer of the phase generator
 Walks the 24 slots after reset and opens the host write window at slot 23
*/
`timescale 1ns/1ns

module pg_sequencer (
	input  logic                         clk,
	input  logic                         arst_n,
	output logic [fm_pg_pkg::slot_w-1:0] rd_slot,
	output logic                         rd_valid,
	output logic                         wr_ready
);

	// Last slot of the frame
	logic frame_end;

	assign frame_end = (rd_slot == fm_pg_pkg::last_slot);

	////////////////////////////////////////
	// Slot counter
	// First edge after reset only starts the run
	// Slot 0 is read in the cycle that follows
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_valid <= 1'b0;
			rd_slot  <= '0;
		end else if (!rd_valid) begin
			rd_valid <= 1'b1;
		end else if (frame_end) begin
			// Wrap to a new frame
			rd_slot <= '0;
		end else begin
			rd_slot <= rd_slot + 1'b1;
		end
	end

	////////////////////////////////////////
	// Write window
	// Open while slot 23 is read
	// A write landing here takes effect from the next frame onwards
	// Host waits up to 23 cycles otherwise
	assign wr_ready = rd_valid && frame_end;

endmodule

// File: slot_cfg_if.sv
/*
 Registered settings of the slot being read, from the store to the pipeline
 Updated once per clock, one cycle behind the sequencer's read slot
*/
`timescale 1ns/1ns

interface slot_cfg_if;

	// Settings of the slot read last cycle
	fm_pg_pkg::slot_cfg_t cfg;

	// Pending key-on, high for one read only
	logic key_on;

	// Sequencer running
	logic rd_valid;

	// Which slot these settings belong to
	logic [fm_pg_pkg::slot_w-1:0] rd_slot;

	// Store side drives everything
	modport store (
		output cfg,
		output key_on,
		output rd_valid,
		output rd_slot
	);

	// Phase pipeline side
	modport gen (
		input cfg,
		input key_on,
		input rd_valid,
		input rd_slot
	);

endinterface

// File: fm_pg_pkg.sv
/*
 Shared sizes, detune tables and slot structs of the FM phase generator
 Design files reach these through scoped names
*/
package fm_pg_pkg;

	////////////////////////////////////////
	// Frame geometry
	localparam int num_slots = 24;
	localparam int slot_w    = 5;
	// Read slot that opens the write window
	localparam logic [slot_w-1:0] last_slot = slot_w'(num_slots - 1);

	// Per-slot setting widths
	localparam int fnum_w  = 11;
	localparam int block_w = 3;
	localparam int mul_w   = 4;
	// Sign in the top bit, amount below
	localparam int dt_w    = 3;

	// Datapath widths
	localparam int phinc_w = 17;
	localparam int acc_w   = 20;
	localparam int phase_w = 10;
	localparam int kc_w    = 5;

	////////////////////////////////////////
	// Latency
	// Read slot to output stream
	localparam int pipe_lat = 7;
	// Phase feedback, one full frame
	localparam int ring_len = num_slots;

	////////////////////////////////////////
	// Detune tables
	// Fractional powers of two, by detuned keycode low bits
	localparam logic [4:0] dt_pow2 [0:7] = '{
		5'd16, 5'd17, 5'd19, 5'd20, 5'd22, 5'd24, 5'd26, 5'd29
	};
	// Offset caps by detune amount
	localparam logic [4:0] dt_limit [0:3] = '{5'd8, 5'd8, 5'd16, 5'd22};

	// One slot's settings, 21 bits
	typedef struct packed {
		logic [fnum_w-1:0]  fnum;
		logic [block_w-1:0] block;
		logic [mul_w-1:0]   mul;
		logic [dt_w-1:0]    dt;
	} slot_cfg_t;

	// Slot tag beside the phase data, 11 bits
	typedef struct packed {
		logic              valid;
		logic [slot_w-1:0] slot;
		logic [kc_w-1:0]   keycode;
	} slot_tag_t;

endpackage
